//--- hist_cfg.svh
`ifndef HIST_CFG_SVH
`define HIST_CFG_SVH

// tdc code and bin sizing
`define HIST_TDC_BITS          6
`define HIST_FINE_BITS         3   // lower code bits, also the bin index width

// acquisition shape
`define HIST_PIXELS            4
`define HIST_EVENTS_PER_PIXEL  2   // per pixel per frame
`define HIST_FRAMES            4   // frames per pass

// events per pixel per pass is 8, so 4 bits never wrap
`define HIST_COUNT_BITS        4

// derived sizes
`define HIST_PIXEL_BITS        $clog2(`HIST_PIXELS)
`define HIST_BINS              (1 << `HIST_FINE_BITS)

`endif

//--- hist_pkg.sv
`include "hist_cfg.svh"

package hist_pkg;

    typedef logic [`HIST_TDC_BITS-1:0]   code_t;
    typedef logic [`HIST_PIXEL_BITS-1:0] pixel_t;
    typedef logic [`HIST_FINE_BITS-1:0]  bin_t;
    typedef logic [`HIST_COUNT_BITS-1:0] count_t;

    typedef enum logic {
        PHASE_COARSE = 1'b0,
        PHASE_FINE   = 1'b1
    } hist_phase_t;

    typedef enum logic [2:0] {
        CLEAR    = 3'd0,
        ACCEPT   = 3'd1,
        UPDATE   = 3'd2,
        ACK_HOLD = 3'd3,
        SCAN     = 3'd4,
        REPORT   = 3'd5
    } hist_state_t;

    typedef enum logic [1:0] {
        RAM_NOP   = 2'd0,
        RAM_INC   = 2'd1,
        RAM_READ  = 2'd2,
        RAM_CLEAR = 2'd3
    } ram_op_t;

    typedef struct packed {
        ram_op_t op;
        pixel_t  pixel;
        bin_t    bin;
        logic    last;    // final read of a pixel scan
    } ram_cmd_t;

    typedef struct packed {
        logic   valid;
        bin_t   bin;
        count_t count;
        logic   last;
    } bin_read_t;

    typedef struct packed {
        hist_phase_t phase;
        pixel_t      pixel;
        bin_t        peak_bin;
        count_t      peak_count;
    } peak_result_t;

endpackage

//--- hist_ctrl.sv
`timescale 1ns/10ps
`include "hist_cfg.svh"

module hist_ctrl (
    input  logic                  clk,
    input  logic                  combin_res,
    input  logic                  ev_req,
    input  logic                  hit,
    input  logic                  report_done,
    input  hist_pkg::bin_t        bin,
    output logic                  ev_ack,
    output hist_pkg::ram_cmd_t    ram_cmd,
    output hist_pkg::pixel_t      pixel,
    output hist_pkg::hist_phase_t phase
);

    localparam int EV_W = $clog2(`HIST_EVENTS_PER_PIXEL + 1);
    localparam int FR_W = $clog2(`HIST_FRAMES + 1);

    hist_pkg::hist_state_t state;
    hist_pkg::pixel_t      pix_cnt;    // pixel for events, scans and clears
    hist_pkg::bin_t        bin_cnt;    // scan and clear bin
    logic [EV_W-1:0]       ev_cnt;
    logic [FR_W-1:0]       frame_cnt;
    logic                  last_ev;
    logic                  last_pix;
    logic                  last_frame;
    logic                  last_bin;

    assign last_ev    = (ev_cnt == EV_W'(`HIST_EVENTS_PER_PIXEL - 1));
    assign last_pix   = (pix_cnt == hist_pkg::pixel_t'(`HIST_PIXELS - 1));
    assign last_frame = (frame_cnt == FR_W'(`HIST_FRAMES - 1));
    assign last_bin   = (bin_cnt == '1);

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            state     <= hist_pkg::CLEAR;
            phase     <= hist_pkg::PHASE_COARSE;
            pix_cnt   <= '0;
            bin_cnt   <= '0;
            ev_cnt    <= '0;
            frame_cnt <= '0;
        end else begin
            case (state)
                hist_pkg::CLEAR: begin
                    bin_cnt <= bin_cnt + 1'b1;
                    if (last_bin) begin
                        pix_cnt <= last_pix ? '0 : pix_cnt + 1'b1;
                        if (last_pix)
                            state <= hist_pkg::ACCEPT;
                    end
                end
                hist_pkg::ACCEPT: begin
                    if (ev_req)
                        state <= hist_pkg::UPDATE;
                end
                hist_pkg::UPDATE: state <= hist_pkg::ACK_HOLD;
                hist_pkg::ACK_HOLD: begin
                    // step the counters once the source drops req
                    if (!ev_req) begin
                        ev_cnt <= last_ev ? '0 : ev_cnt + 1'b1;
                        if (last_ev) begin
                            pix_cnt <= last_pix ? '0 : pix_cnt + 1'b1;
                            if (last_pix)
                                frame_cnt <= last_frame ? '0 : frame_cnt + 1'b1;
                        end
                        if (last_ev && last_pix && last_frame)
                            state <= hist_pkg::SCAN;   // pass complete with pix_cnt back at 0
                        else
                            state <= hist_pkg::ACCEPT;
                    end
                end
                hist_pkg::SCAN: begin
                    bin_cnt <= bin_cnt + 1'b1;
                    if (last_bin)
                        state <= hist_pkg::REPORT;
                end
                hist_pkg::REPORT: begin
                    if (report_done) begin
                        if (last_pix) begin
                            pix_cnt <= '0;
                            state   <= hist_pkg::CLEAR;
                            phase   <= (phase == hist_pkg::PHASE_COARSE) ?
                                       hist_pkg::PHASE_FINE : hist_pkg::PHASE_COARSE;
                        end else begin
                            pix_cnt <= pix_cnt + 1'b1;
                            state   <= hist_pkg::SCAN;
                        end
                    end
                end
                default: state <= hist_pkg::CLEAR;
            endcase
        end
    end

    always_comb begin
        ram_cmd.op    = hist_pkg::RAM_NOP;
        ram_cmd.pixel = pix_cnt;
        ram_cmd.bin   = bin_cnt;
        ram_cmd.last  = 1'b0;
        case (state)
            hist_pkg::CLEAR: ram_cmd.op = hist_pkg::RAM_CLEAR;
            hist_pkg::UPDATE: begin
                ram_cmd.op  = hit ? hist_pkg::RAM_INC : hist_pkg::RAM_NOP;  // misses are dropped
                ram_cmd.bin = bin;
            end
            hist_pkg::SCAN: begin
                ram_cmd.op   = hist_pkg::RAM_READ;
                ram_cmd.last = last_bin;
            end
            default: ;
        endcase
    end

    assign ev_ack = (state == hist_pkg::ACK_HOLD);
    assign pixel  = pix_cnt;

    // source side of the four-phase event link
    a_req_drop: assert property (@(posedge clk) disable iff (!combin_res)
        $fell(ev_req) |-> ev_ack);

    a_req_raise: assert property (@(posedge clk) disable iff (!combin_res)
        $rose(ev_req) |-> !ev_ack);

endmodule

//--- window_mapper.sv
`timescale 1ns/10ps
`include "hist_cfg.svh"

module window_mapper (
    input  logic                   clk,
    input  logic                   combin_res,
    input  hist_pkg::code_t        ev_code,
    input  hist_pkg::pixel_t       pixel,
    input  hist_pkg::hist_phase_t  phase,
    input  logic                   res_req,
    input  hist_pkg::peak_result_t res_data,
    output hist_pkg::bin_t         bin,
    output logic                   hit
);

    hist_pkg::bin_t coarse_peak [`HIST_PIXELS];   // one coarse peak per pixel
    logic           res_req_q;
    logic           capture;
    hist_pkg::bin_t upper;
    hist_pkg::bin_t lower;

    // coarse field is the top bin-width bits of the code
    assign upper   = ev_code[`HIST_TDC_BITS-1 -: `HIST_FINE_BITS];
    assign lower   = ev_code[`HIST_FINE_BITS-1:0];
    assign capture = res_req && !res_req_q && (res_data.phase == hist_pkg::PHASE_COARSE);

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res)
            res_req_q <= 1'b0;
        else
            res_req_q <= res_req;   // edge detect on the result link
    end

    always_ff @(posedge clk) begin
        if (capture)
            coarse_peak[res_data.pixel] <= res_data.peak_bin;
    end

    always_comb begin
        if (phase == hist_pkg::PHASE_COARSE) begin
            bin = upper;
            hit = 1'b1;
        end else begin
            // fine window around this pixel's coarse peak
            bin = lower;
            hit = (upper == coarse_peak[pixel]);
        end
    end

endmodule

//--- bin_ram.sv
`timescale 1ns/10ps
`include "hist_cfg.svh"

module bin_ram (
    input  logic                clk,
    input  logic                combin_res,
    input  hist_pkg::ram_cmd_t  ram_cmd,
    output hist_pkg::bin_read_t rd
);

    localparam int DEPTH  = `HIST_PIXELS * `HIST_BINS;
    localparam int ADDR_W = `HIST_PIXEL_BITS + `HIST_FINE_BITS;

    hist_pkg::count_t  mem [DEPTH];
    logic [ADDR_W-1:0] addr;
    hist_pkg::count_t  cur_count;
    logic              valid_q;
    logic              last_q;
    hist_pkg::bin_t    bin_q;
    hist_pkg::count_t  count_q;

    assign addr      = {ram_cmd.pixel, ram_cmd.bin};   // pixel major
    assign cur_count = mem[addr];

    // read-modify-write in one cycle at one address
    always_ff @(posedge clk) begin
        case (ram_cmd.op)
            hist_pkg::RAM_INC:   mem[addr] <= cur_count + 1'b1;
            hist_pkg::RAM_CLEAR: mem[addr] <= '0;
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (ram_cmd.op == hist_pkg::RAM_READ) begin
            bin_q   <= ram_cmd.bin;
            count_q <= cur_count;
            last_q  <= ram_cmd.last;
        end
    end

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res)
            valid_q <= 1'b0;
        else
            valid_q <= (ram_cmd.op == hist_pkg::RAM_READ);   // one cycle read latency
    end

    assign rd = '{valid: valid_q, bin: bin_q, count: count_q, last: last_q};

    // counter width is sized so a pass never overflows a bin
    a_no_wrap: assert property (@(posedge clk) disable iff (!combin_res)
        (ram_cmd.op == hist_pkg::RAM_INC) |-> (cur_count != '1));

endmodule

//--- peak_finder.sv
`timescale 1ns/10ps

module peak_finder (
    input  logic                   clk,
    input  logic                   combin_res,
    input  hist_pkg::bin_read_t    rd,
    input  hist_pkg::pixel_t       pixel,
    input  hist_pkg::hist_phase_t  phase,
    input  logic                   res_ack,
    output logic                   res_req,
    output hist_pkg::peak_result_t res_data,
    output logic                   report_done
);

    hist_pkg::bin_t   best_bin;
    hist_pkg::count_t best_count;
    hist_pkg::bin_t   cand_bin;
    hist_pkg::count_t cand_count;
    logic             first_q;    // next read opens a scan
    logic             wait_low;   // ack seen high, waiting for it to fall
    logic             take;

    // strictly greater only, lowest bin wins a tie
    assign take       = first_q || (rd.count > best_count);
    assign cand_bin   = take ? rd.bin : best_bin;
    assign cand_count = take ? rd.count : best_count;

    always_ff @(posedge clk) begin
        if (rd.valid) begin
            best_bin   <= cand_bin;
            best_count <= cand_count;
        end
        if (rd.valid && rd.last)
            res_data <= '{phase: phase, pixel: pixel, peak_bin: cand_bin,
                          peak_count: cand_count};
    end

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            first_q     <= 1'b1;
            res_req     <= 1'b0;
            wait_low    <= 1'b0;
            report_done <= 1'b0;
        end else begin
            report_done <= 1'b0;
            if (rd.valid)
                first_q <= rd.last;
            if (rd.valid && rd.last) begin
                res_req <= 1'b1;
            end else if (res_req && res_ack) begin
                res_req  <= 1'b0;
                wait_low <= 1'b1;
            end else if (wait_low && !res_ack) begin
                wait_low    <= 1'b0;
                report_done <= 1'b1;   // single pulse back to the controller
            end
        end
    end

    a_data_stable: assert property (@(posedge clk) disable iff (!combin_res)
        res_req |=> (!res_req || $stable(res_data)));

    // controller must hold off the next scan until the handshake closes
    a_no_overrun: assert property (@(posedge clk) disable iff (!combin_res)
        (rd.valid && rd.last) |-> !(res_req || wait_low));

endmodule

//--- hist_top.sv
`timescale 1ns/10ps

module hist_top (
    input  logic                   clk,
    input  logic                   combin_res,
    input  logic                   ev_req,
    input  hist_pkg::code_t        ev_code,
    input  logic                   res_ack,
    output logic                   ev_ack,
    output logic                   res_req,
    output hist_pkg::peak_result_t res_data
);

    hist_pkg::ram_cmd_t    ram_cmd;
    hist_pkg::bin_read_t   rd;
    hist_pkg::pixel_t      pixel;
    hist_pkg::hist_phase_t phase;
    hist_pkg::bin_t        bin;
    logic                  hit;
    logic                  report_done;

    hist_ctrl u_ctrl (
        .clk         (clk),
        .combin_res  (combin_res),
        .ev_req      (ev_req),
        .hit         (hit),
        .report_done (report_done),
        .bin         (bin),
        .ev_ack      (ev_ack),
        .ram_cmd     (ram_cmd),
        .pixel       (pixel),
        .phase       (phase)
    );

    // also snoops the result link for coarse peaks
    window_mapper u_mapper (
        .clk        (clk),
        .combin_res (combin_res),
        .ev_code    (ev_code),
        .pixel      (pixel),
        .phase      (phase),
        .res_req    (res_req),
        .res_data   (res_data),
        .bin        (bin),
        .hit        (hit)
    );

    bin_ram u_ram (
        .clk        (clk),
        .combin_res (combin_res),
        .ram_cmd    (ram_cmd),
        .rd         (rd)
    );

    peak_finder u_peak (
        .clk         (clk),
        .combin_res  (combin_res),
        .rd          (rd),
        .pixel       (pixel),
        .phase       (phase),
        .res_ack     (res_ack),
        .res_req     (res_req),
        .res_data    (res_data),
        .report_done (report_done)
    );

endmodule

//--- tb_hist.sv
`timescale 1ns/10ps
`include "hist_cfg.svh"

module tb_hist;

    localparam int EPP          = `HIST_EVENTS_PER_PIXEL;
    localparam int PIXELS       = `HIST_PIXELS;
    localparam int FRAMES       = `HIST_FRAMES;
    localparam int BINS         = `HIST_BINS;
    localparam int CYCLES       = 2;    // coarse+fine cycles
    localparam int N_EVENTS     = CYCLES * 2 * FRAMES * PIXELS * EPP;
    localparam int N_RESULTS    = CYCLES * 2 * PIXELS;
    localparam int N_SWEEPS     = CYCLES * 2 + 1;   // after reset and after every pass
    localparam int CLEAR_CYCLES = PIXELS * BINS;
    localparam int CYCLE_LIMIT  = N_EVENTS * 8 + N_RESULTS * 20 + N_SWEEPS * 40;

    logic                   clk;
    logic                   combin_res;
    logic                   ev_req;
    hist_pkg::code_t        ev_code;
    logic                   ev_ack;
    logic                   res_ack;
    logic                   res_req;
    hist_pkg::peak_result_t res_data;

    hist_pkg::code_t        code_tab [N_EVENTS];
    hist_pkg::peak_result_t exp_tab  [N_RESULTS];
    integer                 seed;
    int                     res_idx;
    int                     cycles;

    hist_top dut (
        .clk        (clk),
        .combin_res (combin_res),
        .ev_req     (ev_req),
        .ev_code    (ev_code),
        .res_ack    (res_ack),
        .ev_ack     (ev_ack),
        .res_req    (res_req),
        .res_data   (res_data)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic check_value(input string what, input int got, input int exp_val);
        if (got != exp_val) begin
            $display("error at %0d ns: %s is %0d, expected %0d", $time, what, got, exp_val);
            $display("TEST FAILED");
            $fatal(1);
        end
    endtask

    // table position of one event in pass, frame, pixel, event order
    function automatic int event_index(input int c, input int ps, input int f,
                                       input int p, input int e);
        return (((c * 2 + ps) * FRAMES + f) * PIXELS + p) * EPP + e;
    endfunction

    task automatic gen_codes();
        int             centre [4];
        int             up;
        logic [31:0]    r;
        hist_pkg::bin_t lo;
        centre = '{1, 3, 2, 6};   // coarse centre per pixel
        seed = 32'h8d31_51d0;
        for (int c = 0; c < CYCLES; c++)
            for (int ps = 0; ps < 2; ps++)
                for (int f = 0; f < FRAMES; f++)
                    for (int p = 0; p < PIXELS; p++)
                        for (int e = 0; e < EPP; e++) begin
                            r  = $random(seed);
                            up = centre[p];
                            if (r[1:0] == 2'd0)
                                up = up - 1;
                            else if (r[1:0] == 2'd3)
                                up = up + 1;
                            // pixel 2 splits evenly between bins 2 and 5
                            if (ps == 0 && p == 2)
                                up = (e == 0) ? 2 : 5;
                            lo = r[4:2];
                            code_tab[event_index(c, ps, f, p, e)] = {hist_pkg::bin_t'(up), lo};
                        end
    endtask

    // expected peaks straight from the histogram rules
    task automatic model_results();
        int              hist [BINS];
        hist_pkg::bin_t  cpeak [PIXELS];
        hist_pkg::code_t code;
        hist_pkg::bin_t  up;
        hist_pkg::bin_t  lo;
        int              best;
        int              ridx;
        ridx = 0;
        for (int c = 0; c < CYCLES; c++)
            for (int ps = 0; ps < 2; ps++)
                for (int p = 0; p < PIXELS; p++) begin
                    for (int b = 0; b < BINS; b++)
                        hist[b] = 0;   // every pass starts from a cleared memory
                    for (int f = 0; f < FRAMES; f++)
                        for (int e = 0; e < EPP; e++) begin
                            code = code_tab[event_index(c, ps, f, p, e)];
                            up   = code[`HIST_TDC_BITS-1 -: `HIST_FINE_BITS];
                            lo   = code[`HIST_FINE_BITS-1:0];
                            if (ps == 0)
                                hist[up]++;
                            else if (up == cpeak[p])
                                hist[lo]++;   // fine window only
                        end
                    best = 0;
                    for (int b = 1; b < BINS; b++)
                        if (hist[b] > hist[best])
                            best = b;   // strict compare so the lowest bin keeps a tie
                    if (ps == 0)
                        cpeak[p] = hist_pkg::bin_t'(best);
                    exp_tab[ridx].phase      = (ps == 0) ? hist_pkg::PHASE_COARSE
                                                         : hist_pkg::PHASE_FINE;
                    exp_tab[ridx].pixel      = hist_pkg::pixel_t'(p);
                    exp_tab[ridx].peak_bin   = hist_pkg::bin_t'(best);
                    exp_tab[ridx].peak_count = hist_pkg::count_t'(hist[best]);
                    ridx++;
                end
    endtask

    // req is already up here
    task automatic finish_event();
        while (!ev_ack)
            @(negedge clk);
        ev_req = 1'b0;
        while (ev_ack)
            @(negedge clk);
    endtask

    task automatic send_event(input hist_pkg::code_t code);
        ev_code = code;
        ev_req  = 1'b1;
        finish_event();
    endtask

    // one result sink cycle with no event ack allowed while a result is open
    task automatic watch_cycle();
        @(negedge clk);
        if (res_req || res_ack)
            check_value("ev_ack during result handshake", int'(ev_ack), 0);
    endtask

    initial begin : result_sink
        logic [31:0] r;
        res_ack = 1'b0;
        res_idx = 0;
        while (res_idx < N_RESULTS) begin
            watch_cycle();
            if (res_req) begin
                check_value($sformatf("result %0d phase", res_idx),
                            int'(res_data.phase), int'(exp_tab[res_idx].phase));
                check_value($sformatf("result %0d pixel", res_idx),
                            int'(res_data.pixel), int'(exp_tab[res_idx].pixel));
                check_value($sformatf("result %0d peak bin", res_idx),
                            int'(res_data.peak_bin), int'(exp_tab[res_idx].peak_bin));
                check_value($sformatf("result %0d peak count", res_idx),
                            int'(res_data.peak_count), int'(exp_tab[res_idx].peak_count));
                res_idx++;
                r = $random(seed);
                repeat (r[2:0])
                    watch_cycle();   // ack delay of 0 to 7 cycles
                res_ack = 1'b1;
                do
                    watch_cycle();
                while (res_req);
                res_ack = 1'b0;
            end
        end
        while (!res_req)
            @(negedge clk);
        $display("an extra result was reported after all %0d expected results", N_RESULTS);
        $display("TEST FAILED");
        $fatal(1);
    end

    initial begin : stimulus
        combin_res = 1'b0;
        ev_req     = 1'b0;
        ev_code    = '0;
        gen_codes();
        model_results();
        repeat (3)
            @(posedge clk);   // three rising edges in reset
        @(negedge clk);
        combin_res = 1'b1;
        // first event is held off by the reset clear sweep
        ev_code = code_tab[0];
        ev_req  = 1'b1;
        repeat (CLEAR_CYCLES) begin
            @(negedge clk);
            check_value("ev_ack during reset clear sweep", int'(ev_ack), 0);
            check_value("res_req during reset clear sweep", int'(res_req), 0);
        end
        finish_event();
        for (int i = 1; i < N_EVENTS; i++) begin
            send_event(code_tab[i]);
        end
        while (res_idx < N_RESULTS || res_req || res_ack)
            @(negedge clk);
        repeat (CLEAR_CYCLES + 8)
            @(negedge clk);   // nothing more may come out during the final sweep
        $display("TEST PASSED");
        $finish;
    end

    initial begin : watchdog
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: the run did not finish within %0d clock cycles", CYCLE_LIMIT);
        $display("TEST FAILED");
        $fatal(1);
    end

endmodule

//--- src.f
+incdir+.
hist_pkg.sv
hist_ctrl.sv
window_mapper.sv
bin_ram.sv
peak_finder.sv
hist_top.sv
tb_hist.sv

//--- Makefile
# Verilator build and run of the histogrammer testbench

LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run tb_hist and check $(LOG) for the pass message"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --top-module tb_hist -f src.f -o sim_hist
	./obj_dir/sim_hist | tee $(LOG)
	grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
